//--- dv/led_control_tb.sv
`timescale 1ns/1ps

module led_control_tb;

  import led_pkg::*;

  // --------------------------------------------------------------------------
  // test configuration
  // --------------------------------------------------------------------------

  // short periods so every source moves within a few hundred cycles
  localparam int gate_len     = 64;
  localparam int scan_len     = 3;
  localparam int blink_len    = 8;
  localparam int flash_len    = 5;
  localparam int reset_cycles = 4;

  // rate scaling and bar geometry
  localparam int windows_per_second = 16;
  localparam int rate_per_led       = 100;
  localparam int bar_width          = 12;
  localparam led_word_t error_a     = 16'h5555;
  localparam led_word_t error_b     = 16'hAAAA;

  // display modes as the model sees them
  localparam int disp_reset  = 0;
  localparam int disp_error  = 1;
  localparam int disp_cylon  = 2;
  localparam int disp_normal = 3;

  // cluster count source per phase
  localparam int count_zero   = 0;
  localparam int count_const  = 1;
  localparam int count_random = 2;

  logic           clock;
  logic           reset;
  logic           mmcm_locked;
  logic           gbt_rxready;
  logic           gbt_rxvalid;
  logic           gbt_request_received;
  cluster_count_t cluster_count;
  rate_t          cluster_rate;
  led_word_t      led_out;

  // stimulus table with one entry per phase
  string       row_name[$];
  logic        row_locked[$];
  logic        row_ready[$];
  logic        row_valid[$];
  logic [15:0] row_req[$];
  int          row_count_mode[$];
  int          row_count_arg[$];
  int          row_len[$];
  string       phase_name;

  // reference model state
  int          gate_pos;
  rate_t       window_acc;
  rate_t       model_rate;
  int          flash_left;
  int          beat_pos;
  logic        model_beat;
  logic        model_seen;
  led_word_t   exp_led;
  int          exp_mode;
  logic        model_valid;

  // scenario coverage
  int          cylon_moves;
  logic [11:0] prev_scan;
  logic        scan_valid;
  logic        seen_a;
  logic        seen_b;
  logic        after_error;
  int          relock_cycles;
  logic        bar_full_seen;
  int          flash_run;
  int          longest_flash;
  int          rate_windows;
  logic [3:0]  link_seen;

  int          cycle_count;
  int          max_cycles;

  led_control #(
    .gate_cycles  (gate_len),
    .scan_cycles  (scan_len),
    .blink_cycles (blink_len),
    .flash_cycles (flash_len)
  ) uut (
    .clock                (clock),
    .reset                (reset),
    .mmcm_locked          (mmcm_locked),
    .gbt_rxready          (gbt_rxready),
    .gbt_rxvalid          (gbt_rxvalid),
    .gbt_request_received (gbt_request_received),
    .cluster_count        (cluster_count),
    .cluster_rate         (cluster_rate),
    .led_out              (led_out)
  );

  // 10 ns period
  always #5 clock = ~clock;

  // --------------------------------------------------------------------------
  // reporting
  // --------------------------------------------------------------------------

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("error: time %0t: %s expected %h actual %h in phase %s", $time, name,
             expected, actual, phase_name);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic stop_with_reason(input string what);
    $display("failure at time %0t in phase %s: %s", $time, phase_name, what);
    $display("Checks failed");
    $fatal(1);
  endtask

  // thermometer of min(rate / 100, 12) leds from bit 0
  function automatic logic [11:0] thermometer(input rate_t rate);
    int unsigned lit;
    lit = rate / rate_per_led;
    if (lit > bar_width) lit = bar_width;
    return 12'((32'd1 << lit) - 32'd1);
  endfunction

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------

  task automatic add_row(input string name, input logic locked, input logic ready,
                         input logic valid, input logic [15:0] req, input int mode,
                         input int arg, input int len);
    row_name.push_back(name);
    row_locked.push_back(locked);
    row_ready.push_back(ready);
    row_valid.push_back(valid);
    row_req.push_back(req);
    row_count_mode.push_back(mode);
    row_count_arg.push_back(arg);
    row_len.push_back(len);
  endtask

  // req is a 16-cycle strobe mask where bit n fires on cycle n of each group
  task automatic build_table();
    //      name           lock  rdy   vld   req       count         arg  len
    add_row("cylon_sweep", 1'b1, 1'b1, 1'b1, 16'h0001, count_zero,   0,   48);
    add_row("cylon_link",  1'b1, 1'b0, 1'b1, 16'h0000, count_zero,   0,   16);
    add_row("const_one",   1'b1, 1'b1, 1'b0, 16'h0005, count_const,  1,   128);
    add_row("random_low",  1'b1, 1'b0, 1'b0, 16'h0101, count_random, 1,   192);
    add_row("unlocked",    1'b0, 1'b1, 1'b1, 16'h0001, count_random, 3,   64);
    add_row("relock_busy", 1'b1, 1'b1, 1'b1, 16'h0001, count_random, 255, 128);
    add_row("quiet",       1'b1, 1'b1, 1'b1, 16'h0000, count_zero,   0,   128);
  endtask

  task automatic drive_cycle(input int row, input int cyc);
    cluster_count_t count;
    case (row_count_mode[row])
      count_const:  count = cluster_count_t'(row_count_arg[row]);
      count_random: count = cluster_count_t'($urandom_range(row_count_arg[row], 0));
      default:      count = '0;
    endcase
    mmcm_locked          <= row_locked[row];
    gbt_rxready          <= row_ready[row];
    gbt_rxvalid          <= row_valid[row];
    gbt_request_received <= row_req[row][cyc % 16];
    cluster_count        <= count;
  endtask

  // --------------------------------------------------------------------------
  // reference model state after each rising edge
  // --------------------------------------------------------------------------

  always @(posedge clock) begin
    if (reset) begin
      gate_pos    = 0;
      window_acc  = '0;
      model_rate  = '0;
      flash_left  = 0;
      beat_pos    = 0;
      model_beat  = 1'b0;
      model_seen  = 1'b0;
      exp_led     = '0;
      exp_mode    = disp_reset;
      model_valid = 1'b1;
    end else begin
      // word registered at this edge from the state before it
      exp_led = {gbt_rxready & gbt_rxvalid, 1'b0, model_beat, flash_left != 0,
                 thermometer(model_rate)};
      if (!mmcm_locked) exp_mode = disp_error;
      else if (!model_seen) exp_mode = disp_cylon;
      else exp_mode = disp_normal;
      if (exp_mode != disp_error) link_seen[{gbt_rxready, gbt_rxvalid}] = 1'b1;
      // last cycle of a window still counts
      if (gate_pos == gate_len - 1) begin
        model_rate = (window_acc + rate_t'(cluster_count)) * windows_per_second;
        window_acc = '0;
        gate_pos   = 0;
        if (model_seen) rate_windows++;
      end else begin
        window_acc = window_acc + rate_t'(cluster_count);
        gate_pos++;
      end
      // retrigger restarts the flash
      if (gbt_request_received) flash_left = flash_len;
      else if (flash_left != 0) flash_left--;
      if (beat_pos == blink_len - 1) begin
        beat_pos   = 0;
        model_beat = ~model_beat;
      end else begin
        beat_pos++;
      end
      if (cluster_count != '0) model_seen = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // output checks at mid-cycle
  // --------------------------------------------------------------------------

  task automatic check_outputs();
    assert (cluster_rate === model_rate)
      else value_mismatch("cluster_rate", model_rate, cluster_rate);
    case (exp_mode)
      disp_reset: begin
        assert (led_out === 16'h0000)
          else value_mismatch("led_out", 32'h0, 32'(led_out));
      end
      disp_error: begin
        assert (led_out === error_a || led_out === error_b)
          else stop_with_reason($sformatf("led_out %h is no error pattern while unlocked",
                                          led_out));
        if (led_out === error_a) seen_a = 1'b1;
        if (led_out === error_b) seen_b = 1'b1;
        after_error = 1'b1;
      end
      disp_cylon: begin
        // upper bits still carry link, heartbeat and flash
        assert (led_out[15:12] === exp_led[15:12])
          else value_mismatch("led_out[15:12]", 32'(exp_led[15:12]), 32'(led_out[15:12]));
        assert ($countones(led_out[11:0]) == 1)
          else stop_with_reason($sformatf("scanner bar %h is not one-hot", led_out[11:0]));
        if (scan_valid && led_out[11:0] != prev_scan) cylon_moves++;
        prev_scan  = led_out[11:0];
        scan_valid = 1'b1;
      end
      default: begin
        assert (led_out === exp_led)
          else value_mismatch("led_out", 32'(exp_led), 32'(led_out));
        if (led_out[11:0] == 12'hFFF) bar_full_seen = 1'b1;
        if (after_error) relock_cycles++;
      end
    endcase
    // flash run length on led_out[12]
    if (exp_mode != disp_error && led_out[12]) flash_run++;
    else flash_run = 0;
    if (flash_run > longest_flash) longest_flash = flash_run;
  endtask

  always @(negedge clock) begin
    if (model_valid) check_outputs();
  end

  // run limit
  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > max_cycles) begin
      stop_with_reason($sformatf("timeout, run still going after %0d cycles", max_cycles));
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    string missing;
    clock                = 1'b0;
    reset                = 1'b1;
    mmcm_locked          = 1'b1;
    gbt_rxready          = 1'b0;
    gbt_rxvalid          = 1'b0;
    gbt_request_received = 1'b0;
    cluster_count        = '0;
    model_valid          = 1'b0;
    cylon_moves          = 0;
    prev_scan            = '0;
    scan_valid           = 1'b0;
    seen_a               = 1'b0;
    seen_b               = 1'b0;
    after_error          = 1'b0;
    relock_cycles        = 0;
    bar_full_seen        = 1'b0;
    flash_run            = 0;
    longest_flash        = 0;
    rate_windows         = 0;
    link_seen            = '0;
    cycle_count          = 0;
    phase_name           = "reset";
    void'($urandom(56));
    build_table();
    max_cycles = 20;
    foreach (row_len[i]) max_cycles += row_len[i];

    // reset released on the edge that drives the first phase
    repeat (reset_cycles - 1) @(posedge clock);
    for (int row = 0; row < row_len.size(); row++) begin
      phase_name = row_name[row];
      for (int cyc = 0; cyc < row_len[row]; cyc++) begin
        @(posedge clock);
        reset <= 1'b0;
        drive_cycle(row, cyc);
      end
    end
    repeat (3) @(negedge clock);

    // every scenario must have happened
    missing = "";
    if (cylon_moves == 0) missing = {missing, " scanner_motion"};
    if (!seen_a || !seen_b) missing = {missing, " both_error_patterns"};
    if (relock_cycles == 0) missing = {missing, " relock"};
    if (!bar_full_seen) missing = {missing, " full_bar"};
    if (longest_flash <= flash_len) missing = {missing, " flash_retrigger"};
    if (rate_windows < 3) missing = {missing, " rate_windows"};
    if (link_seen != 4'hF) missing = {missing, " link_combinations"};
    if (missing.len() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      stop_with_reason({"scenarios not exercised:", missing});
    end
  end

endmodule

//--- led_control.f
source/led_pkg.sv
source/rate_counter.sv
source/cylon_scanner.sv
source/error_indicator.sv
source/pulse_stretcher.sv
source/led_control.sv
dv/led_control_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the led_control testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  -f led_control.f \
  --top-module led_control_tb \
  --Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

"./$build_dir/Vled_control_tb"
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- source/cylon_scanner.sv
`timescale 1ns/1ps

module cylon_scanner #(
  parameter int unsigned scan_cycles = led_pkg::default_scan_cycles
) (
  input  logic          clock,
  input  logic          reset,
  output led_pkg::bar_t scan_bar
);

  import led_pkg::*;

  localparam int unsigned tick_bits = $clog2(scan_cycles + 1);
  localparam logic [tick_bits-1:0] tick_last = tick_bits'(scan_cycles - 1);

  logic [tick_bits-1:0] tick_count;
  logic                 tick;
  bar_t                 position;
  scan_dir_t            direction;

  // --------------------------------------------------------------------------
  // move divider
  // --------------------------------------------------------------------------

  assign tick = (tick_count == tick_last);

  always_ff @(posedge clock) begin
    if (reset || tick) begin
      tick_count <= '0;
    end else begin
      tick_count <= tick_count + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // one-hot position and direction
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      position  <= bar_t'(1);
      direction <= scan_up;
    end else if (tick) begin
      case (direction)
        scan_up: begin
          position <= position << 1;
          // about to land on the top led, turn around
          if (position[bar_leds-2]) direction <= scan_down;
        end
        default: begin
          position <= position >> 1;
          // about to land on bit 0
          if (position[1]) direction <= scan_up;
        end
      endcase
    end
  end

  assign scan_bar = position;

endmodule

//--- source/error_indicator.sv
`timescale 1ns/1ps

module error_indicator #(
  parameter int unsigned blink_cycles = led_pkg::default_blink_cycles
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               unlocked,
  output led_pkg::led_word_t err_leds
);

  import led_pkg::*;

  localparam int unsigned blink_bits = $clog2(blink_cycles + 1);
  localparam logic [blink_bits-1:0] blink_last = blink_bits'(blink_cycles - 1);

  logic [blink_bits-1:0] blink_count;
  // low selects pattern a
  logic                  phase;

  // --------------------------------------------------------------------------
  // blink divider, only runs while unlocked
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset || !unlocked) begin
      // hold at pattern a while locked
      blink_count <= '0;
      phase       <= 1'b0;
    end else if (blink_count == blink_last) begin
      blink_count <= '0;
      phase       <= ~phase;
    end else begin
      blink_count <= blink_count + 1'b1;
    end
  end

  // pattern select
  assign err_leds = phase ? err_pattern_b : err_pattern_a;

endmodule

//--- source/led_control.sv
`timescale 1ns/1ps

module led_control #(
  parameter int unsigned gate_cycles  = led_pkg::default_gate_cycles,
  parameter int unsigned scan_cycles  = led_pkg::default_scan_cycles,
  parameter int unsigned blink_cycles = led_pkg::default_blink_cycles,
  parameter int unsigned flash_cycles = led_pkg::default_flash_cycles
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    mmcm_locked,
  input  logic                    gbt_rxready,
  input  logic                    gbt_rxvalid,
  input  logic                    gbt_request_received,
  input  led_pkg::cluster_count_t cluster_count,
  output led_pkg::rate_t          cluster_rate,
  output led_pkg::led_word_t      led_out
);

  import led_pkg::*;

  localparam int unsigned beat_bits = $clog2(blink_cycles + 1);
  localparam logic [beat_bits-1:0] beat_last = beat_bits'(blink_cycles - 1);

  bar_t                 progress_bar;
  bar_t                 scan_bar;
  led_word_t            err_leds;
  logic                 flash;
  logic [beat_bits-1:0] beat_count;
  logic                 heartbeat;
  logic                 first_cluster_seen;
  led_word_t            logic_word;
  led_word_t            led_word;

  // --------------------------------------------------------------------------
  // pattern sources
  // --------------------------------------------------------------------------

  rate_counter #(.gate_cycles(gate_cycles)) u_rate_counter (
    .clock        (clock),
    .reset        (reset),
    .increment    (cluster_count),
    .rate         (cluster_rate),
    .progress_bar (progress_bar)
  );

  // sweeps until the first cluster shows up
  cylon_scanner #(.scan_cycles(scan_cycles)) u_cylon_scanner (
    .clock    (clock),
    .reset    (reset),
    .scan_bar (scan_bar)
  );

  error_indicator #(.blink_cycles(blink_cycles)) u_error_indicator (
    .clock    (clock),
    .reset    (reset),
    .unlocked (!mmcm_locked),
    .err_leds (err_leds)
  );

  // link request flash
  pulse_stretcher #(.flash_cycles(flash_cycles)) u_pulse_stretcher (
    .clock   (clock),
    .reset   (reset),
    .trigger (gbt_request_received),
    .flash   (flash)
  );

  // --------------------------------------------------------------------------
  // heartbeat and first-cluster latch
  // --------------------------------------------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      beat_count <= '0;
      heartbeat  <= 1'b0;
    end else if (beat_count == beat_last) begin
      beat_count <= '0;
      heartbeat  <= ~heartbeat;
    end else begin
      beat_count <= beat_count + 1'b1;
    end
  end

  // sticky until reset, ends cylon mode
  always_ff @(posedge clock) begin
    if (reset) first_cluster_seen <= 1'b0;
    else if (cluster_count != '0) first_cluster_seen <= 1'b1;
  end

  // --------------------------------------------------------------------------
  // mode mux and output register
  // --------------------------------------------------------------------------

  // bit 14 reserved, link clock blinker not present
  assign logic_word = {gbt_rxready & gbt_rxvalid, 1'b0, heartbeat, flash, progress_bar};

  always_comb begin
    if (!mmcm_locked) led_word = err_leds;
    else if (!first_cluster_seen) led_word = {logic_word[15:bar_leds], scan_bar};
    else led_word = logic_word;
  end

  always_ff @(posedge clock) begin
    if (reset) led_out <= '0;
    else led_out <= led_word;
  end

endmodule

//--- source/led_pkg.sv
package led_pkg;

  // --------------------------------------------------------------------------
  // display geometry and rate scaling
  // --------------------------------------------------------------------------

  // bar leds on the front panel
  localparam int unsigned bar_leds = 12;

  // sixteen gate windows per second, so sum times 16
  localparam int unsigned rate_shift = 4;

  // rate worth one lit bar led
  localparam int unsigned bar_step = 100;

  // --------------------------------------------------------------------------
  // board default periods, in clock cycles
  // --------------------------------------------------------------------------

  // board clock over 16
  localparam int unsigned default_gate_cycles  = 2504937;
  localparam int unsigned default_scan_cycles  = 2500000;
  // heartbeat and error blink half-period
  localparam int unsigned default_blink_cycles = 1048576;
  localparam int unsigned default_flash_cycles = 4000000;

  // error patterns, alternate leds lit
  localparam logic [15:0] err_pattern_a = 16'h5555;
  localparam logic [15:0] err_pattern_b = 16'hAAAA;

  // --------------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------------

  // one bit per front-panel led
  typedef logic [15:0] led_word_t;
  // thermometer bar
  typedef logic [bar_leds-1:0] bar_t;
  // clusters seen in one clock cycle
  typedef logic [7:0] cluster_count_t;
  // cluster rate, counts per second
  typedef logic [31:0] rate_t;

  // scanner sweep direction
  typedef enum logic {
    scan_up,
    scan_down
  } scan_dir_t;

endpackage

//--- source/pulse_stretcher.sv
`timescale 1ns/1ps

module pulse_stretcher #(
  parameter int unsigned flash_cycles = led_pkg::default_flash_cycles
) (
  input  logic clock,
  input  logic reset,
  input  logic trigger,
  output logic flash
);

  localparam int unsigned flash_bits = $clog2(flash_cycles + 1);
  localparam logic [flash_bits-1:0] flash_load = flash_bits'(flash_cycles);

  // cycles of flash still to show
  logic [flash_bits-1:0] remaining;

  // load on trigger, retrigger restarts the count
  always_ff @(posedge clock) begin
    if (reset) begin
      remaining <= '0;
    end else if (trigger) begin
      remaining <= flash_load;
    end else if (remaining != '0) begin
      remaining <= remaining - 1'b1;
    end
  end

  // lit while counting down
  assign flash = (remaining != '0);

endmodule

//--- source/rate_counter.sv
`timescale 1ns/1ps

module rate_counter #(
  parameter int unsigned gate_cycles = led_pkg::default_gate_cycles
) (
  input  logic                    clock,
  input  logic                    reset,
  input  led_pkg::cluster_count_t increment,
  output led_pkg::rate_t          rate,
  output led_pkg::bar_t           progress_bar
);

  import led_pkg::*;

  // gate counter width, wide enough to hold gate_cycles - 1
  localparam int unsigned gate_bits = $clog2(gate_cycles + 1);
  localparam logic [gate_bits-1:0] gate_last = gate_bits'(gate_cycles - 1);

  logic [gate_bits-1:0] gate_count;
  logic                 window_end;
  rate_t                accumulator;
  rate_t                window_sum;

  // --------------------------------------------------------------------------
  // gate window
  // --------------------------------------------------------------------------

  // high on the last cycle of each window
  assign window_end = (gate_count == gate_last);

  // windows run back to back from the first cycle after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      gate_count <= '0;
    end else if (window_end) begin
      gate_count <= '0;
    end else begin
      gate_count <= gate_count + 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // accumulate and latch
  // --------------------------------------------------------------------------

  // sum including this cycle's count
  assign window_sum = accumulator + rate_t'(increment);

  always_ff @(posedge clock) begin
    if (reset) begin
      accumulator <= '0;
      rate        <= '0;
    end else if (window_end) begin
      // last count goes into this window, next window starts empty
      accumulator <= '0;
      rate        <= window_sum << rate_shift;
    end else begin
      accumulator <= window_sum;
    end
  end

  // --------------------------------------------------------------------------
  // thermometer bar
  // --------------------------------------------------------------------------

  // led i lit once rate reaches (i + 1) steps
  // saturates naturally at bar_leds
  always_comb begin
    progress_bar = '0;
    for (int i = 0; i < bar_leds; i++) begin
      progress_bar[i] = (rate >= rate_t'((i + 1) * bar_step));
    end
  end

endmodule
